// File: verilog/cpu16_params.svh
`ifndef CPU16_PARAMS_SVH
`define CPU16_PARAMS_SVH

`define CPU16_DATA_W 16
`define CPU16_REG_N 16
`define CPU16_IMEM_DEPTH 256
`define CPU16_APB_AW 12

// Byte addresses on the APB port.
`define CPU16_ADDR_CTRL 'h000
`define CPU16_ADDR_STATUS 'h004
`define CPU16_ADDR_PC 'h008

// Word i of each window sits at base plus 4i.
`define CPU16_IMEM_BASE 'h400
`define CPU16_REG_BASE 'h800

// CTRL bit 0 starts the core.
// STATUS bit 0 busy, bit 1 halted, bits 4..2 N V Z.

`endif

// File: verilog/cpu16Pkg.sv
`default_nettype none

`include "cpu16_params.svh"

package cpu16Pkg;

  typedef logic [`CPU16_DATA_W-1:0] word_t;
  typedef logic [$clog2(`CPU16_REG_N)-1:0] regIdx_t;
  typedef logic [$clog2(`CPU16_IMEM_DEPTH)-1:0] imemAddr_t; // Also the PC.

  typedef enum logic [3:0] {
    ADD = 4'h0,
    SUB = 4'h1,
    AND = 4'h2,
    XOR = 4'h3,
    SLL = 4'h4,
    SRA = 4'h5,
    LLI = 4'h6,
    LHI = 4'h7,
    B   = 4'h8,
    HLT = 4'hf
  } opcode_t;

  typedef struct packed {
    logic n;
    logic v;
    logic z;
  } flags_t;

  // Every field view of one instruction word.
  typedef struct packed {
    opcode_t    op;
    regIdx_t    rd;
    regIdx_t    rs;
    regIdx_t    rt;
    logic [7:0] imm8;
    logic [2:0] cond;
    logic [8:0] offset9; // Two's complement.
  } decoded_t;

  typedef enum logic [1:0] {
    IDLE,
    FETCH,
    EXEC,
    HALT
  } ctrlState_t;

endpackage

`default_nettype wire

// File: verilog/regFile.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu16_params.svh"

module regFile import cpu16Pkg::*; (
  input  wire logic    clk,
  input  wire logic    rstN,
  input  wire regIdx_t srcReg1,
  input  wire regIdx_t srcReg2,
  input  wire regIdx_t dstReg,
  input  wire logic    writeReg,
  input  wire word_t   dstData,
  output word_t        srcData1,
  output word_t        srcData2
);

  // Register 0 has no storage.
  logic [`CPU16_REG_N-1:1] wordline;
  word_t                   regs [1:`CPU16_REG_N-1];

  // Write decoder, one strobe per register.
  always_comb begin
    for (int i = 1; i < `CPU16_REG_N; i++) begin
      wordline[i] = writeReg && (dstReg == regIdx_t'(i));
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 1; i < `CPU16_REG_N; i++) begin
        regs[i] <= '0;
      end
    end else begin
      for (int i = 1; i < `CPU16_REG_N; i++) begin
        if (wordline[i]) begin
          regs[i] <= dstData;
        end
      end
    end
  end

  // Muxed read ports.
  always_comb begin
    srcData1 = '0;
    srcData2 = '0;
    if (srcReg1 != '0) begin
      srcData1 = regs[srcReg1];
    end
    if (srcReg2 != '0) begin
      srcData2 = regs[srcReg2];
    end
  end

endmodule

`default_nettype wire

// File: verilog/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu import cpu16Pkg::*; (
  input  wire opcode_t    op,
  input  wire word_t      a,
  input  wire word_t      b,
  input  wire logic [7:0] imm8,
  input  wire logic [3:0] shamt,
  output word_t           result,
  output flags_t          flagsOut
);

  localparam int Msb = $bits(word_t) - 1;

  word_t sum;
  word_t diff;
  logic  addOvf;
  logic  subOvf;

  assign sum  = a + b;
  assign diff = a - b;

  // Same-sign operands giving a different-sign result.
  assign addOvf = (a[Msb] == b[Msb]) && (sum[Msb] != a[Msb]);
  assign subOvf = (a[Msb] != b[Msb]) && (diff[Msb] != a[Msb]);

  always_comb begin
    case (op)
      ADD: result = sum;
      SUB: result = diff;
      AND: result = a & b;
      XOR: result = a ^ b;
      SLL: result = a << shamt;
      SRA: result = word_t'($signed(a) >>> shamt); // Sign fill.
      LLI: result = word_t'(imm8);
      LHI: result = {imm8, a[7:0]};
      default: result = '0;
    endcase
  end

  always_comb begin
    flagsOut.n = result[Msb];
    flagsOut.z = (result == '0);
    case (op)
      ADD: flagsOut.v = addOvf;
      SUB: flagsOut.v = subOvf;
      default: flagsOut.v = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/instrMem.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu16_params.svh"

module instrMem import cpu16Pkg::*; (
  input  wire logic      clk,
  input  wire logic      we,
  input  wire imemAddr_t waddr,
  input  wire word_t     wdata,
  input  wire imemAddr_t raddr,
  output word_t          rdata
);

  word_t mem [`CPU16_IMEM_DEPTH];

  // Host load port.
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // Core fetch port, one cycle of latency.
  always_ff @(posedge clk) begin
    rdata <= mem[raddr];
  end

endmodule

`default_nettype wire

// File: verilog/apbRegs.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu16_params.svh"

module apbRegs import cpu16Pkg::*; (
  input  wire logic                     clk,
  input  wire logic                     rstN,
  input  wire logic                     psel,
  input  wire logic                     penable,
  input  wire logic                     pwrite,
  input  wire logic [`CPU16_APB_AW-1:0] paddr,
  input  wire word_t                    pwdata,
  input  wire logic                     busy,
  input  wire logic                     halted,
  input  wire flags_t                   flags,
  input  wire imemAddr_t                pc,
  input  wire word_t                    srcData1,
  output word_t                         prdata,
  output logic                          pready,
  output logic                          pslverr,
  output logic                          start,
  output regIdx_t                       dbgReg,
  output logic                          imemWe,
  output imemAddr_t                     imemWaddr,
  output word_t                         imemWdata
);

  localparam int unsigned ImemEnd = `CPU16_IMEM_BASE + 4 * `CPU16_IMEM_DEPTH;
  localparam int unsigned RegEnd  = `CPU16_REG_BASE + 4 * `CPU16_REG_N;

  int unsigned addr;
  logic        access;
  logic        aligned;
  logic        hitCtrl;
  logic        hitStatus;
  logic        hitPc;
  logic        hitImem;
  logic        hitReg;
  logic        mapped;

  assign addr    = 32'(paddr);
  assign access  = psel && penable; // Access phase, pready is always high.
  assign aligned = (paddr[1:0] == 2'b00);

  assign hitCtrl   = (addr == `CPU16_ADDR_CTRL);
  assign hitStatus = (addr == `CPU16_ADDR_STATUS);
  assign hitPc     = (addr == `CPU16_ADDR_PC);
  assign hitImem   = aligned && (addr >= `CPU16_IMEM_BASE) && (addr < ImemEnd);
  assign hitReg    = aligned && (addr >= `CPU16_REG_BASE) && (addr < RegEnd);
  assign mapped    = hitCtrl || hitStatus || hitPc || hitImem || hitReg;

  // Memory and register file belong to the core while it runs.
  assign pslverr = access &&
                   (!mapped || (busy && ((hitImem && pwrite) || (hitReg && !pwrite))));
  assign pready  = 1'b1;

  assign imemWe    = access && pwrite && hitImem && !busy;
  assign imemWaddr = imemAddr_t'(paddr >> 2);
  assign imemWdata = pwdata;
  assign dbgReg    = regIdx_t'(paddr >> 2); // Used by the core only when idle.

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      start <= 1'b0;
    end else begin
      start <= access && pwrite && hitCtrl && pwdata[0];
    end
  end

  always_comb begin
    prdata = '0;
    if (hitStatus) begin
      prdata = word_t'({flags, halted, busy});
    end else if (hitPc) begin
      prdata = word_t'(pc);
    end else if (hitReg && !busy) begin
      prdata = srcData1;
    end
  end

endmodule

`default_nettype wire

// File: verilog/cpuCtrl.sv
`timescale 1ns/10ps
`default_nettype none

module cpuCtrl import cpu16Pkg::*; (
  input  wire logic    clk,
  input  wire logic    rstN,
  input  wire logic    start,
  input  wire regIdx_t dbgReg,
  input  wire word_t   instr,
  input  wire word_t   aluResult,
  input  wire flags_t  aluFlags,
  output logic         busy,
  output logic         halted,
  output flags_t       flags,
  output imemAddr_t    pc,
  output imemAddr_t    fetchAddr,
  output regIdx_t      srcReg1,
  output regIdx_t      srcReg2,
  output regIdx_t      dstReg,
  output logic         writeReg,
  output opcode_t      aluOp,
  output logic [7:0]   imm8
);

  ctrlState_t state;
  ctrlState_t stateNext;
  decoded_t   dec;
  logic       execute;
  logic       writesRd;
  logic       writesNv;
  logic       writesZ;
  logic       taken;
  logic [8:0] target;
  imemAddr_t  pcNext;

  assign busy    = (state == FETCH) || (state == EXEC);
  assign halted  = (state == HALT);
  assign execute = (state == EXEC);

  always_comb begin
    dec.op      = opcode_t'(instr[15:12]);
    dec.rd      = instr[11:8];
    dec.rs      = instr[7:4];
    dec.rt      = instr[3:0];
    dec.imm8    = instr[7:0];
    dec.cond    = instr[11:9];
    dec.offset9 = instr[8:0];
  end

  // Write-back and flag masks.
  always_comb begin
    writesRd = 1'b0;
    writesNv = 1'b0;
    writesZ  = 1'b0;
    case (dec.op)
      ADD, SUB: begin
        writesRd = 1'b1;
        writesNv = 1'b1;
        writesZ  = 1'b1;
      end
      AND, XOR, SLL, SRA: begin
        writesRd = 1'b1;
        writesZ  = 1'b1;
      end
      LLI, LHI: begin
        writesRd = 1'b1;
      end
      default: begin
      end
    endcase
  end

  always_comb begin
    case (dec.cond)
      3'b000: taken = !flags.z;
      3'b001: taken = flags.z;
      3'b010: taken = !flags.z && !flags.n;
      3'b011: taken = flags.n;
      3'b100: taken = flags.v;
      3'b111: taken = 1'b1;
      default: taken = 1'b0;
    endcase
  end

  // Offset is relative to the next instruction, wraps at 256.
  assign target = 9'(pc) + 9'd1 + dec.offset9;
  assign pcNext = (dec.op == B && taken) ? imemAddr_t'(target) : pc + 1'b1;

  always_comb begin
    stateNext = state;
    case (state)
      IDLE, HALT: begin
        if (start) begin
          stateNext = FETCH;
        end
      end
      FETCH: stateNext = EXEC;
      EXEC: stateNext = (dec.op == HLT) ? HALT : FETCH;
      default: stateNext = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state <= IDLE;
      pc    <= '0;
      flags <= '0;
    end else begin
      state <= stateNext;
      if (!busy && start) begin
        pc <= '0;
      end else if (execute && dec.op != HLT) begin
        pc <= pcNext; // HLT keeps its own address.
      end
      if (execute && writesNv) begin
        flags.n <= aluFlags.n;
        flags.v <= aluFlags.v;
      end
      if (execute && writesZ) begin
        flags.z <= aluFlags.z;
      end
    end
  end

  assign fetchAddr = pc;
  assign srcReg1   = !busy ? dbgReg : ((dec.op == LHI) ? dec.rd : dec.rs);
  assign srcReg2   = dec.rt; // Shift amount for SLL and SRA.
  assign dstReg    = dec.rd;
  assign writeReg  = execute && writesRd;
  assign aluOp     = dec.op;
  assign imm8      = dec.imm8;

endmodule

`default_nettype wire

// File: verilog/cpu16Top.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu16_params.svh"

module cpu16Top import cpu16Pkg::*; (
  input  wire logic                     clk,
  input  wire logic                     rstN,
  input  wire logic                     psel,
  input  wire logic                     penable,
  input  wire logic                     pwrite,
  input  wire logic [`CPU16_APB_AW-1:0] paddr,
  input  wire word_t                    pwdata,
  output word_t                         prdata,
  output logic                          pready,
  output logic                          pslverr
);

  logic       busy;
  logic       halted;
  flags_t     flags;
  imemAddr_t  pc;
  logic       start;
  regIdx_t    dbgReg;
  logic       imemWe;
  imemAddr_t  imemWaddr;
  word_t      imemWdata;
  imemAddr_t  fetchAddr;
  word_t      instr;
  regIdx_t    srcReg1;
  regIdx_t    srcReg2;
  regIdx_t    dstReg;
  logic       writeReg;
  word_t      srcData1;
  word_t      srcData2;
  opcode_t    aluOp;
  logic [7:0] imm8;
  word_t      aluResult;
  flags_t     aluFlags;

  apbRegs apbRegs0 (
    .clk, .rstN, .psel, .penable, .pwrite, .paddr, .pwdata,
    .busy, .halted, .flags, .pc, .srcData1,
    .prdata, .pready, .pslverr, .start, .dbgReg,
    .imemWe, .imemWaddr, .imemWdata
  );

  instrMem instrMem0 (
    .clk, .we(imemWe), .waddr(imemWaddr), .wdata(imemWdata),
    .raddr(fetchAddr), .rdata(instr)
  );

  cpuCtrl cpuCtrl0 (
    .clk, .rstN, .start, .dbgReg, .instr, .aluResult, .aluFlags,
    .busy, .halted, .flags, .pc, .fetchAddr,
    .srcReg1, .srcReg2, .dstReg, .writeReg, .aluOp, .imm8
  );

  regFile regFile0 (
    .clk, .rstN, .srcReg1, .srcReg2, .dstReg, .writeReg,
    .dstData(aluResult), .srcData1, .srcData2
  );

  // The rt field doubles as the shift amount.
  alu alu0 (
    .op(aluOp), .a(srcData1), .b(srcData2), .imm8, .shamt(srcReg2),
    .result(aluResult), .flagsOut(aluFlags)
  );

endmodule

`default_nettype wire

// File: verif/cpu16Tasks.svh
`ifndef CPU16_TASKS_SVH
`define CPU16_TASKS_SVH

function automatic word_t encReg(opcode_t op, int rd, int rs, int rt);
  return {4'(op), 4'(rd), 4'(rs), 4'(rt)};
endfunction

function automatic word_t encImm(opcode_t op, int rd, int imm);
  return {4'(op), 4'(rd), 8'(imm)};
endfunction

function automatic word_t encBranch(int cond, int offset);
  return {4'(B), 3'(cond), 9'(offset)}; // Offset from the next instruction.
endfunction

function automatic word_t encHalt();
  return {4'(HLT), 12'h000};
endfunction

task automatic apbWrite(input int addr, input word_t data, output logic err);
  @(posedge clk);
  #10;
  psel    = 1'b1;
  penable = 1'b0;
  pwrite  = 1'b1;
  paddr   = 12'(addr);
  pwdata  = data;
  @(posedge clk);
  #10;
  penable = 1'b1;
  #30;
  err = pslverr; // Mid access cycle.
  @(posedge clk);
  #10;
  psel    = 1'b0;
  penable = 1'b0;
  pwrite  = 1'b0;
endtask

task automatic apbRead(input int addr, output word_t data, output logic err);
  @(posedge clk);
  #10;
  psel    = 1'b1;
  penable = 1'b0;
  pwrite  = 1'b0;
  paddr   = 12'(addr);
  @(posedge clk);
  #10;
  penable = 1'b1;
  #30;
  data = prdata;
  err  = pslverr;
  @(posedge clk);
  #10;
  psel    = 1'b0;
  penable = 1'b0;
endtask

// Host load of the current program, mirrored into the model memory.
task automatic loadProgram();
  logic err;
  foreach (prog[i]) begin
    apbWrite(`CPU16_IMEM_BASE + 4 * i, prog[i], err);
    checkValue("load ack", 16'h0, 16'(err));
    modelMem[i] = prog[i];
  end
endtask

`endif

// File: verif/cpu16Tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu16_params.svh"

module cpu16Tb import cpu16Pkg::*; ();

  localparam int MaxCycles = 4000;

  logic                     clk;
  logic                     rstN;
  logic                     psel;
  logic                     penable;
  logic                     pwrite;
  logic [`CPU16_APB_AW-1:0] paddr;
  word_t                    pwdata;
  word_t                    prdata;
  logic                     pready;
  logic                     pslverr;

  word_t prog [$];
  word_t modelMem [256];
  word_t modelRegs [16];
  logic  mN;
  logic  mV;
  logic  mZ;
  int    errors;
  int    checks;
  int    tests;
  int    testStartErrors;
  int    cycles;

  cpu16Top dut0 (
    .clk, .rstN, .psel, .penable, .pwrite, .paddr, .pwdata,
    .prdata, .pready, .pslverr
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MaxCycles) begin
      $display("Timeout after %0d cycles, the core or the bus never finished.", cycles);
      $display("TB FAILED");
      $finish;
    end
  end

  apbReadyHigh: assert property (@(posedge clk) disable iff (!rstN) pready)
    else begin
      $display("pready dropped low on the APB port.");
      errors++;
    end

  apbReadKnown: assert property (@(posedge clk) disable iff (!rstN)
      (psel && penable && !pwrite) |-> !$isunknown(prdata))
    else begin
      $display("prdata is unknown in a read access cycle.");
      errors++;
    end

  task automatic checkValue(input string name, input word_t exp, input word_t act);
    checks++;
    assert (act === exp)
      else begin
        $display("** Error %s: expected %h, actual %h", name, exp, act);
        errors++;
      end
  endtask

  `include "cpu16Tasks.svh"

  task automatic beginTest();
    testStartErrors = errors;
    prog.delete();
  endtask

  task automatic endTest(input string name);
    tests++;
    if (errors == testStartErrors) begin
      $display("Test %s: ok", name);
    end else begin
      $display("Test %s: %0d errors", name, errors - testStartErrors);
    end
  endtask

  // Instruction-level model of the core from the ISA rules.
  task automatic modelRun();
    word_t w;
    word_t a;
    word_t b;
    word_t r;
    int    p;
    int    rd;
    int    sa;
    int    sb;
    int    full;
    logic  wr;
    logic  tk;
    p = 0;
    for (int step = 0; step < 1000; step++) begin
      w  = modelMem[p];
      rd = int'(w[11:8]);
      a  = modelRegs[w[7:4]];
      b  = modelRegs[w[3:0]];
      sa = $signed(a);
      sb = $signed(b);
      wr = 1'b1;
      r  = '0;
      case (w[15:12])
        4'h0, 4'h1: begin
          full = (w[15:12] == 4'h0) ? sa + sb : sa - sb;
          r  = full[15:0];
          mN = r[15];
          mV = (full > 32767) || (full < -32768);
          mZ = (r == 0);
        end
        4'h2: r = a & b;
        4'h3: r = a ^ b;
        4'h4: r = a << w[3:0];
        4'h5: r = 16'(sa >>> w[3:0]);
        4'h6: r = {8'h00, w[7:0]};
        4'h7: r = {w[7:0], modelRegs[rd][7:0]};
        4'h8: begin
          wr = 1'b0;
          case (w[11:9])
            3'd0: tk = !mZ;
            3'd1: tk = mZ;
            3'd2: tk = !mZ && !mN;
            3'd3: tk = mN;
            3'd4: tk = mV;
            3'd7: tk = 1'b1;
            default: tk = 1'b0;
          endcase
          full = $signed(w[8:0]);
          p = tk ? (p + 1 + full) & 255 : (p + 1) & 255;
        end
        default: begin
          return; // HLT.
        end
      endcase
      if (w[15:12] != 4'h8) begin
        if (w[15:12] >= 4'h2 && w[15:12] <= 4'h5) begin
          mZ = (r == 0);
        end
        if (wr && rd != 0) begin
          modelRegs[rd] = r;
        end
        p = (p + 1) & 255;
      end
    end
  endtask

  task automatic runAndWait();
    word_t st;
    logic  err;
    apbWrite(`CPU16_ADDR_CTRL, 16'h0001, err);
    do begin
      apbRead(`CPU16_ADDR_STATUS, st, err);
    end while (!st[1]);
    modelRun();
  endtask

  task automatic compareRegs(input string name);
    word_t d;
    logic  err;
    for (int i = 0; i < 16; i++) begin
      apbRead(`CPU16_REG_BASE + 4 * i, d, err);
      checkValue($sformatf("%s r%0d", name, i), modelRegs[i], d);
      checkValue($sformatf("%s r%0d slverr", name, i), 16'h0, 16'(err));
    end
  endtask

  task automatic compareStatus(input string name, input logic busyExp, input logic haltExp);
    word_t d;
    logic  err;
    apbRead(`CPU16_ADDR_STATUS, d, err);
    checkValue({name, " status"}, {11'h0, mN, mV, mZ, haltExp, busyExp}, d);
  endtask

  task automatic buildValue(input int rd, input word_t val);
    prog.push_back(encImm(LLI, rd, val[7:0]));
    prog.push_back(encImm(LHI, rd, val[15:8]));
  endtask

  task automatic branchTest(input int cond);
    word_t d;
    logic  err;
    beginTest();
    for (int i = 12; i < 16; i++) begin
      prog.push_back(encImm(LLI, i, 0));
    end
    prog.push_back(encReg(SUB, 10, 1, 1)); // Z set.
    prog.push_back(encBranch(cond, 1));
    prog.push_back(encImm(LLI, 12, 8'ha1));
    prog.push_back(encImm(LLI, 11, 1)); // All clear.
    prog.push_back(encReg(SUB, 10, 11, 0));
    prog.push_back(encBranch(cond, 1));
    prog.push_back(encImm(LLI, 13, 8'ha2));
    buildValue(11, 16'h8000); // N set.
    prog.push_back(encReg(SUB, 10, 11, 0));
    prog.push_back(encBranch(cond, 1));
    prog.push_back(encImm(LLI, 14, 8'ha3));
    buildValue(11, 16'h7fff); // N and V set.
    prog.push_back(encImm(LLI, 9, 1));
    prog.push_back(encReg(ADD, 10, 11, 9));
    prog.push_back(encBranch(cond, 1));
    prog.push_back(encImm(LLI, 15, 8'ha4));
    prog.push_back(encHalt());
    loadProgram();
    runAndWait();
    compareRegs($sformatf("branch%0d", cond));
    apbRead(`CPU16_ADDR_PC, d, err);
    checkValue($sformatf("branch%0d pc", cond), 16'(prog.size() - 1), d);
    endTest($sformatf("branch cond %0d", cond));
  endtask

  initial begin
    word_t d;
    word_t v;
    logic  err;
    int    conds [7];
    conds   = '{0, 1, 2, 3, 4, 7, 5};
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    rstN    = 1'b0;
    errors  = 0;
    checks  = 0;
    tests   = 0;
    cycles  = 0;
    mN = 1'b0;
    mV = 1'b0;
    mZ = 1'b0;
    foreach (modelRegs[i]) modelRegs[i] = '0;
    foreach (modelMem[i]) modelMem[i] = encHalt();
    void'($urandom(32'hed84_c173));
    repeat (5) @(posedge clk);
    #10 rstN = 1'b1;

    beginTest();
    compareStatus("reset", 1'b0, 1'b0);
    compareRegs("reset");
    endTest("reset state");

    beginTest();
    for (int i = 1; i <= 4; i++) begin
      buildValue(i, 16'($urandom));
    end
    prog.push_back(encReg(ADD, 5, 1, 2));
    prog.push_back(encReg(SUB, 6, 1, 3));
    prog.push_back(encReg(AND, 7, 2, 4));
    prog.push_back(encReg(XOR, 8, 3, 4));
    prog.push_back(encImm(LLI, 0, 8'h55));
    prog.push_back(encReg(ADD, 0, 1, 2));
    prog.push_back(encHalt());
    loadProgram();
    runAndWait();
    compareRegs("arith");
    endTest("arithmetic");

    beginTest();
    buildValue(1, 16'h7fff);
    prog.push_back(encImm(LLI, 2, 1));
    prog.push_back(encReg(ADD, 3, 1, 2));
    prog.push_back(encHalt());
    loadProgram();
    runAndWait();
    compareStatus("flags add", 1'b0, 1'b1);
    prog.delete();
    prog.push_back(encReg(AND, 4, 2, 0));
    prog.push_back(encHalt());
    loadProgram();
    runAndWait();
    compareStatus("flags and", 1'b0, 1'b1);
    compareRegs("flags");
    endTest("flags");

    beginTest();
    v = 16'($urandom) | 16'h8000;
    buildValue(1, v);
    buildValue(2, 16'($urandom) & 16'h7fff);
    prog.push_back(encReg(SLL, 3, 1, int'($urandom % 16)));
    prog.push_back(encReg(SRA, 4, 1, int'($urandom % 16)));
    prog.push_back(encReg(SRA, 5, 2, int'($urandom % 16)));
    prog.push_back(encReg(SRA, 6, 1, 15));
    prog.push_back(encHalt());
    loadProgram();
    runAndWait();
    compareRegs("shift");
    endTest("shifts");

    foreach (conds[i]) begin
      branchTest(conds[i]);
    end

    beginTest();
    prog.push_back(encImm(LLI, 1, 20));
    prog.push_back(encImm(LLI, 2, 1));
    prog.push_back(encReg(SUB, 1, 1, 2));
    prog.push_back(encBranch(0, -2)); // Count down to zero.
    prog.push_back(encImm(LLI, 3, 8'h5a));
    prog.push_back(encHalt());
    loadProgram();
    apbWrite(`CPU16_ADDR_CTRL, 16'h0001, err);
    apbRead(`CPU16_ADDR_STATUS, d, err);
    checkValue("busy status", 16'h0001, d & 16'h0003);
    apbWrite(`CPU16_IMEM_BASE + 16, encImm(LLI, 3, 8'h11), err);
    checkValue("busy imem write slverr", 16'h1, 16'(err));
    apbRead(`CPU16_REG_BASE + 4, d, err);
    checkValue("busy reg read slverr", 16'h1, 16'(err));
    apbRead('h100, d, err);
    checkValue("unmapped slverr", 16'h1, 16'(err));
    do begin
      apbRead(`CPU16_ADDR_STATUS, d, err);
    end while (!d[1]);
    modelRun();
    compareStatus("halted", 1'b0, 1'b1);
    compareRegs("busy");
    endTest("error responses");

    $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: cpu16.f
+incdir+verilog
+incdir+verif
verilog/cpu16Pkg.sv
verilog/regFile.sv
verilog/alu.sv
verilog/instrMem.sv
verilog/apbRegs.sv
verilog/cpuCtrl.sv
verilog/cpu16Top.sv
verif/cpu16Tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module cpu16Tb -f cpu16.f \
  --Mdir build -o cpu16Sim

./build/cpu16Sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TB FAILED" sim.log; then
  exit 1
fi
if ! grep -q "TB PASSED" sim.log; then
  echo "Simulation ended without a result line."
  exit 1
fi
exit 0
